//--- run_sim.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_uart_com -f src.f -o sim_uart

# The log decides the result, so a nonzero exit here is not fatal on its own
./obj_dir/sim_uart > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
fi

echo "run_sim: simulation failed, see sim.log"
exit 1

//--- src.f
uart_pkg.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_ctrl.sv
uart_com.sv
tb_uart_com.sv

//--- tb_uart_com.sv
module tb_uart_com;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_khz = 10_000;
    localparam int baud    = 125_000;
    // Remote device timing worked out from the line rate alone
    localparam int bit_clks  = clk_khz * 1000 / baud;
    localparam int tick_clks = bit_clks / 8;
    localparam int max_ops   = 64;

    // Trace operation codes
    localparam logic [7:0] op_send       = 8'h00;
    localparam logic [7:0] op_send_pair  = 8'h01;
    localparam logic [7:0] op_remote     = 8'h02;
    localparam logic [7:0] op_remote_bad = 8'h03;
    localparam logic [7:0] op_read       = 8'h04;
    localparam logic [7:0] op_clear      = 8'h05;
    localparam logic [7:0] op_end        = 8'hff;

    logic                   input_clk;
    logic                   reset;
    logic                   trans_en;
    logic                   rx_read;
    logic                   status_clear;
    logic [7:0]             data_out;
    logic                   remote_rx;
    logic                   loop_en;
    logic                   watch_busy;
    logic                   gap_seen;
    wire                    rx_line;
    logic                   tx;
    logic                   tx_busy;
    logic [7:0]             data_received;
    uart_pkg::uart_status_t status;
    logic [2:0]             status_bits;

    logic [7:0] trace_mem [0:3*max_ops-1];
    int         n_ops;
    int         err_cnt     = 0;
    int         fail_tests  = 0;
    int         cycle_cnt   = 0;
    int         cycle_limit = 0;

    // Loopback feeds tx straight back into the receiver
    assign rx_line     = loop_en ? tx : remote_rx;
    assign status_bits = status;

    uart_com #(
        .input_clk_khz(clk_khz),
        .baud_rate    (baud)
    ) dut0 (
        .input_clk    (input_clk),
        .reset        (reset),
        .trans_en     (trans_en),
        .rx           (rx_line),
        .rx_read      (rx_read),
        .status_clear (status_clear),
        .data_out     (data_out),
        .tx           (tx),
        .tx_busy      (tx_busy),
        .data_received(data_received),
        .status       (status)
    );

    initial begin
        input_clk = 1'b0;
        forever #50 input_clk = ~input_clk;
    end

    // Run limit scales with the trace length
    always @(posedge input_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Run stopped: cycle limit of %0d reached", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // tx_busy must hold for the whole of a transfer
    always @(negedge input_clk) begin
        if (watch_busy && tx_busy !== 1'b1 && !gap_seen) begin
            $display("Problem at %0d ns: tx_busy dropped during a transfer", $time);
            err_cnt++;
            gap_seen = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        $display("ERR %0d ns: %s expected %02h, got %02h", $time, name, exp, got);
        err_cnt++;
    endtask

    task automatic report_problem(input string what);
        $display("Problem at %0d ns: %s", $time, what);
        err_cnt++;
    endtask

    task automatic wait_clks(input int n);
        repeat (n) @(negedge input_clk);
    endtask

    function automatic string op_name(input logic [7:0] op);
        case (op)
            op_send:       return "send";
            op_send_pair:  return "send_pair";
            op_remote:     return "remote_send";
            op_remote_bad: return "remote_bad_stop";
            op_read:       return "read";
            op_clear:      return "clear";
            default:       return "unknown";
        endcase
    endfunction

    task automatic strobe_send(input logic [7:0] data);
        data_out = data;
        trans_en = 1'b1;
        @(negedge input_clk);
        trans_en = 1'b0;
    endtask

    // Waits for the falling start edge on tx
    task automatic wait_start(output int waited, output bit found);
        waited = 0;
        found  = 1'b0;
        while (!found && waited < 2 * bit_clks) begin
            @(negedge input_clk);
            waited++;
            if (tx === 1'b0) begin
                found = 1'b1;
            end
        end
    endtask

    // Remote receiver sampling tx at mid-bit
    task automatic decode_frame(output logic [7:0] data, output int latency);
        bit found;
        data = 8'h00;
        wait_start(latency, found);
        if (!found) begin
            report_problem("no start bit seen on tx");
        end else begin
            wait_clks(bit_clks / 2);
            if (tx !== 1'b0) begin
                report_mismatch("tx start bit", {7'b0, tx}, 8'h00);
            end
            for (int i = 0; i < 8; i++) begin
                wait_clks(bit_clks);
                data[i] = tx;
            end
            wait_clks(bit_clks);
            if (tx !== 1'b1) begin
                report_mismatch("tx stop bit", {7'b0, tx}, 8'h01);
            end
        end
    endtask

    // Remote transmitter sending LSB first
    task automatic send_remote(input logic [7:0] data, input logic stop_level);
        remote_rx = 1'b0;
        wait_clks(bit_clks);
        for (int i = 0; i < 8; i++) begin
            remote_rx = data[i];
            wait_clks(bit_clks);
        end
        remote_rx = stop_level;
        wait_clks(bit_clks);
        remote_rx = 1'b1;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (tx_busy === 1'b1 && waited < bit_clks) begin
            @(negedge input_clk);
            waited++;
        end
        if (tx_busy !== 1'b0) begin
            report_problem("tx_busy did not fall after the stop bit");
        end
    endtask

    task automatic check_idle_state();
        if (tx !== 1'b1) begin
            report_mismatch("tx", {7'b0, tx}, 8'h01);
        end
        if (tx_busy !== 1'b0) begin
            report_mismatch("tx_busy", {7'b0, tx_busy}, 8'h00);
        end
        if (status_bits !== 3'b000) begin
            report_mismatch("status", {5'b0, status_bits}, 8'h00);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [7:0] op;
        logic [7:0] b;
        logic [7:0] flag;
        logic [7:0] got1;
        logic [7:0] got2;
        logic       rdy_before;
        int         lat1;
        int         lat2;
        int         errs_before;

        void'($urandom(32'h9a53));
        reset        = 1'b0;
        trans_en     = 1'b0;
        rx_read      = 1'b0;
        status_clear = 1'b0;
        data_out     = 8'h00;
        remote_rx    = 1'b1;
        loop_en      = 1'b0;
        watch_busy   = 1'b0;
        gap_seen     = 1'b0;

        $readmemh("uart_trace.txt", trace_mem);
        n_ops = 0;
        while (n_ops < max_ops && trace_mem[3*n_ops] != op_end) begin
            n_ops++;
        end
        cycle_limit = n_ops * 2000;

        // Reset state is checked inside and just after reset
        errs_before = err_cnt;
        wait_clks(4);
        check_idle_state();
        wait_clks(4);
        reset = 1'b1;
        wait_clks(2);
        check_idle_state();
        if (err_cnt != errs_before) begin
            fail_tests++;
        end
        $display("test 0 reset: %s", (err_cnt == errs_before) ? "ok" : "bad");

        for (int i = 0; i < n_ops; i++) begin
            op          = trace_mem[3*i];
            b           = trace_mem[3*i+1];
            flag        = trace_mem[3*i+2];
            errs_before = err_cnt;
            gap_seen    = 1'b0;
            rdy_before  = status.data_rdy;
            case (op)
                op_send: begin
                    loop_en = flag[3];
                    strobe_send(b);
                    if (tx_busy !== 1'b1) begin
                        report_mismatch("tx_busy", {7'b0, tx_busy}, 8'h01);
                    end
                    watch_busy = 1'b1;
                    decode_frame(got1, lat1);
                    watch_busy = 1'b0;
                    if (lat1 > tick_clks + 2) begin
                        report_problem("start bit came late after trans_en");
                    end
                    if (got1 !== b) begin
                        report_mismatch("tx data", got1, b);
                    end
                    wait_idle();
                    wait_clks(2);
                    if (flag[3] && !rdy_before && data_received !== b) begin
                        report_mismatch("data_received", data_received, b);
                    end
                    loop_en = 1'b0;
                end
                op_send_pair: begin
                    strobe_send(b);
                    if (tx_busy !== 1'b1) begin
                        report_mismatch("tx_busy", {7'b0, tx_busy}, 8'h01);
                    end
                    watch_busy = 1'b1;
                    // Second byte goes in while the first is on the line
                    fork
                        begin
                            decode_frame(got1, lat1);
                            decode_frame(got2, lat2);
                        end
                        begin
                            wait_clks(2 * bit_clks);
                            strobe_send(~b);
                        end
                    join
                    watch_busy = 1'b0;
                    if (lat1 > tick_clks + 2) begin
                        report_problem("start bit came late after trans_en");
                    end
                    // Pending byte starts within a tick of the first stop bit ending
                    if (lat2 > bit_clks / 2 + tick_clks + 2) begin
                        report_problem("second byte did not follow the first");
                    end
                    if (got1 !== b) begin
                        report_mismatch("tx data first", got1, b);
                    end
                    if (got2 !== ~b) begin
                        report_mismatch("tx data second", got2, ~b);
                    end
                    wait_idle();
                end
                op_remote, op_remote_bad: begin
                    send_remote(b, op == op_remote);
                    wait_clks(2);
                    if (op == op_remote && !rdy_before && data_received !== b) begin
                        report_mismatch("data_received", data_received, b);
                    end
                end
                op_read: begin
                    if (data_received !== b) begin
                        report_mismatch("data_received", data_received, b);
                    end
                    rx_read = 1'b1;
                    @(negedge input_clk);
                    rx_read = 1'b0;
                    wait_clks(1);
                end
                op_clear: begin
                    status_clear = 1'b1;
                    @(negedge input_clk);
                    status_clear = 1'b0;
                    wait_clks(1);
                end
                default: begin
                    report_problem("unknown operation code in trace");
                end
            endcase
            if (status_bits !== flag[2:0]) begin
                report_mismatch("status", {5'b0, status_bits}, {5'b0, flag[2:0]});
            end
            if (err_cnt != errs_before) begin
                fail_tests++;
            end
            $display("test %0d %s %02h: %s", i + 1, op_name(op), b,
                     (err_cnt == errs_before) ? "ok" : "bad");
            // Idle gap long enough for the receiver to settle after a bad stop bit
            wait_clks(40 + int'($urandom % 80));
        end

        $display("Tests run %0d, tests bad %0d, errors %0d", n_ops + 1, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- uart_baud_gen.sv
module uart_baud_gen #(
    parameter int input_clk_khz = 100_000,
    parameter int baud_rate     = 9600
) (
    input  logic input_clk,
    input  logic reset,
    output logic tick_8x
);

    // Clocks per oversample tick
    localparam int div_ratio = (input_clk_khz * 1000) / (baud_rate * uart_pkg::oversample);
    localparam int cnt_w     = (div_ratio > 2) ? $clog2(div_ratio) : 1;
    localparam logic [cnt_w-1:0] last_count = cnt_w'(div_ratio - 1);

    logic [cnt_w-1:0] div_cnt;

    //////////////////////////////////////////////////
    // Divider
    //////////////////////////////////////////////////

    // Counts from zero after reset, so the first tick lands one full period later
    always_ff @(posedge input_clk or negedge reset) begin
        if (!reset) begin
            div_cnt <= '0;
            tick_8x <= 1'b0;
        end else begin
            if (div_cnt == last_count) begin
                div_cnt <= '0;
                tick_8x <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick_8x <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A ratio below 2 would leave the tick stuck high
    div_ratio_ok: assert property (
        @(posedge input_clk) disable iff (!reset)
        div_ratio >= 2
    ) else $error("uart_baud_gen: divide ratio %0d is below 2", div_ratio);

endmodule

//--- uart_com.sv
module uart_com #(
    parameter int input_clk_khz = 100_000,
    parameter int baud_rate     = 9600
) (
    input  logic                   input_clk,
    input  logic                   reset,
    input  logic                   trans_en,
    input  logic                   rx,
    input  logic                   rx_read,
    input  logic                   status_clear,
    input  logic [7:0]             data_out,
    output logic                   tx,
    output logic                   tx_busy,
    output logic [7:0]             data_received,
    output uart_pkg::uart_status_t status
);

    logic                tick_8x;
    logic                tx_active;
    uart_pkg::tx_req_t   tx_req;
    uart_pkg::rx_frame_t rx_frame;

    // Shared oversample tick
    uart_baud_gen #(
        .input_clk_khz(input_clk_khz),
        .baud_rate    (baud_rate)
    ) baud_gen0 (
        .input_clk(input_clk),
        .reset    (reset),
        .tick_8x  (tick_8x)
    );

    uart_tx tx0 (
        .input_clk(input_clk),
        .reset    (reset),
        .tick_8x  (tick_8x),
        .req      (tx_req),
        .tx       (tx),
        .tx_active(tx_active)
    );

    uart_rx rx0 (
        .input_clk(input_clk),
        .reset    (reset),
        .tick_8x  (tick_8x),
        .rx       (rx),
        .frame    (rx_frame)
    );

    // Slot, receive register and status flags
    uart_ctrl ctrl0 (
        .input_clk    (input_clk),
        .reset        (reset),
        .trans_en     (trans_en),
        .data_out     (data_out),
        .rx_read      (rx_read),
        .status_clear (status_clear),
        .tx_active    (tx_active),
        .frame        (rx_frame),
        .tx_req       (tx_req),
        .tx_busy      (tx_busy),
        .data_received(data_received),
        .status       (status)
    );

endmodule

//--- uart_ctrl.sv
module uart_ctrl (
    input  logic                   input_clk,
    input  logic                   reset,
    input  logic                   trans_en,
    input  logic [7:0]             data_out,
    input  logic                   rx_read,
    input  logic                   status_clear,
    input  logic                   tx_active,
    input  uart_pkg::rx_frame_t    frame,
    output uart_pkg::tx_req_t      tx_req,
    output logic                   tx_busy,
    output logic [7:0]             data_received,
    output uart_pkg::uart_status_t status
);

    logic       slot_full;
    logic [7:0] slot_data;
    logic       active_q;
    logic       accept_seen;
    logic       slot_load;
    logic       rx_capture;
    logic       rx_overrun;
    logic       rdy_flag;
    logic       overrun_flag;
    logic       frame_err_flag;

    //////////////////////////////////////////////////
    // Transmit slot
    //////////////////////////////////////////////////

    // Rising tx_active means the transmitter took the slot byte
    assign accept_seen = tx_active & ~active_q;
    // A full slot takes no new byte unless it is being emptied now
    assign slot_load   = trans_en & (~slot_full | accept_seen);

    assign tx_req.valid = slot_full;
    assign tx_req.data  = slot_data;
    assign tx_busy      = slot_full | tx_active;

    always_ff @(posedge input_clk or negedge reset) begin
        if (!reset) begin
            slot_full <= 1'b0;
            active_q  <= 1'b0;
        end else begin
            active_q <= tx_active;
            if (accept_seen) begin
                slot_full <= 1'b0;
            end
            if (slot_load) begin
                slot_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge input_clk) begin
        if (slot_load) begin
            slot_data <= data_out;
        end
    end

    //////////////////////////////////////////////////
    // Receive byte and status
    //////////////////////////////////////////////////

    // A read in the same cycle frees the holding register
    assign rx_capture = frame.valid & ~frame.frame_err & (~rdy_flag | rx_read);
    assign rx_overrun = frame.valid & ~frame.frame_err & rdy_flag & ~rx_read;

    always_ff @(posedge input_clk or negedge reset) begin
        if (!reset) begin
            rdy_flag       <= 1'b0;
            overrun_flag   <= 1'b0;
            frame_err_flag <= 1'b0;
        end else begin
            if (rx_read) begin
                rdy_flag <= 1'b0;
            end
            if (status_clear) begin
                overrun_flag   <= 1'b0;
                frame_err_flag <= 1'b0;
            end
            // New events win over a clear in the same cycle
            if (rx_capture) begin
                rdy_flag <= 1'b1;
            end
            if (rx_overrun) begin
                overrun_flag <= 1'b1;
            end
            if (frame.valid && frame.frame_err) begin
                frame_err_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge input_clk) begin
        if (rx_capture) begin
            data_received <= frame.data;
        end
    end

    assign status.data_rdy  = rdy_flag;
    assign status.overrun   = overrun_flag;
    assign status.frame_err = frame_err_flag;

endmodule

//--- uart_pkg.sv
package uart_pkg;

    //////////////////////////////////////////////////
    // Bit timing
    //////////////////////////////////////////////////

    // Ticks per serial bit, the receiver samples at the middle one
    localparam int oversample = 8;

    //////////////////////////////////////////////////
    // Datapath transfers
    //////////////////////////////////////////////////

    // Byte handed from the control block to the transmitter
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_req_t;

    // One finished frame from the receiver
    typedef struct packed {
        logic       valid;
        logic       frame_err;
        logic [7:0] data;
    } rx_frame_t;

    // Sticky status seen at the top level
    typedef struct packed {
        logic data_rdy;
        logic overrun;
        logic frame_err;
    } uart_status_t;

    //////////////////////////////////////////////////
    // FSM states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

//--- uart_rx.sv
module uart_rx (
    input  logic                input_clk,
    input  logic                reset,
    input  logic                tick_8x,
    input  logic                rx,
    output uart_pkg::rx_frame_t frame
);

    localparam int cnt_w = $clog2(uart_pkg::oversample);
    localparam logic [cnt_w-1:0] last_tick = cnt_w'(uart_pkg::oversample - 1);
    localparam logic [cnt_w-1:0] mid_tick  = cnt_w'(uart_pkg::oversample / 2 - 1);

    uart_pkg::rx_state_t state;
    logic                rx_meta;
    logic                rx_sync;
    logic [cnt_w-1:0]    tick_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift_reg;
    logic                frame_valid;
    logic                frame_err;

    assign frame.valid     = frame_valid;
    assign frame.frame_err = frame_err;
    assign frame.data      = shift_reg;

    //////////////////////////////////////////////////
    // Input synchronizer
    //////////////////////////////////////////////////

    // Idles high so reset does not look like a start bit
    always_ff @(posedge input_clk or negedge reset) begin
        if (!reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge input_clk or negedge reset) begin
        if (!reset) begin
            state       <= uart_pkg::rx_idle;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            shift_reg   <= '0;
            frame_valid <= 1'b0;
            frame_err   <= 1'b0;
        end else begin
            frame_valid <= 1'b0;

            if (tick_8x) begin
                case (state)
                    uart_pkg::rx_idle: begin
                        // First low sample opens a possible frame
                        if (!rx_sync) begin
                            tick_cnt <= '0;
                            state    <= uart_pkg::rx_start;
                        end
                    end

                    uart_pkg::rx_start: begin
                        if (tick_cnt == mid_tick) begin
                            tick_cnt <= '0;
                            bit_idx  <= '0;
                            // High at mid start bit means a glitch
                            if (rx_sync) begin
                                state <= uart_pkg::rx_idle;
                            end else begin
                                state <= uart_pkg::rx_data;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end

                    uart_pkg::rx_data: begin
                        // From here on every sample falls at mid-bit
                        if (tick_cnt == last_tick) begin
                            tick_cnt  <= '0;
                            shift_reg <= {rx_sync, shift_reg[7:1]};
                            bit_idx   <= bit_idx + 1'b1;
                            if (bit_idx == 3'd7) begin
                                state <= uart_pkg::rx_stop;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end

                    uart_pkg::rx_stop: begin
                        if (tick_cnt == last_tick) begin
                            tick_cnt    <= '0;
                            frame_valid <= 1'b1;
                            frame_err   <= !rx_sync;
                            state       <= uart_pkg::rx_idle;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end

                    default: begin
                        state <= uart_pkg::rx_idle;
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // One pulse per frame, the control block counts on it
    frame_single_pulse: assert property (
        @(posedge input_clk) disable iff (!reset)
        frame.valid |=> !frame.valid
    );

endmodule

//--- uart_trace.txt
// Columns: operation, data byte, flag
// Operations: 00 send, 01 send_pair, 02 remote_send, 03 remote_bad_stop, 04 read, 05 clear
// Flag bit 3 selects loopback on send, bits 2:0 are the expected status after the line
// Status bits are data_rdy, overrun, frame_err; send_pair sends the byte then its inverse
00 a5 00
00 01 00
01 3c 00
01 80 00
02 5a 04
04 5a 00
02 c3 04
02 7e 06
04 c3 02
05 00 00
03 99 01
05 00 00
00 e7 0c
04 e7 00
02 00 04
02 ff 06
05 00 04
04 00 00
03 55 01
02 81 05
04 81 01
05 00 00
00 ff 0c
04 ff 00
01 c9 00
// End of trace
ff 00 00

//--- uart_tx.sv
module uart_tx (
    input  logic              input_clk,
    input  logic              reset,
    input  logic              tick_8x,
    input  uart_pkg::tx_req_t req,
    output logic              tx,
    output logic              tx_active
);

    localparam int cnt_w = $clog2(uart_pkg::oversample);
    localparam logic [cnt_w-1:0] last_tick = cnt_w'(uart_pkg::oversample - 1);

    uart_pkg::tx_state_t state;
    logic [cnt_w-1:0]    tick_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift_reg;
    logic                bit_done;

    // Last oversample tick of the current bit
    assign bit_done = tick_8x && (tick_cnt == last_tick);

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge input_clk or negedge reset) begin
        if (!reset) begin
            state     <= uart_pkg::tx_idle;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            shift_reg <= '0;
            tx        <= 1'b1;
            tx_active <= 1'b0;
        end else begin
            // Per-bit tick counter, cleared at every bit boundary
            if (state != uart_pkg::tx_idle && tick_8x) begin
                if (bit_done) begin
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end

            case (state)
                uart_pkg::tx_idle: begin
                    // Byte is taken on a tick so the start bit is a full bit long
                    if (tick_8x && req.valid) begin
                        shift_reg <= req.data;
                        tick_cnt  <= '0;
                        tx        <= 1'b0;
                        tx_active <= 1'b1;
                        state     <= uart_pkg::tx_start;
                    end
                end

                uart_pkg::tx_start: begin
                    if (bit_done) begin
                        bit_idx <= '0;
                        tx      <= shift_reg[0];
                        state   <= uart_pkg::tx_data;
                    end
                end

                uart_pkg::tx_data: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= uart_pkg::tx_stop;
                        end else begin
                            // LSB first, next bit shifts down into place
                            shift_reg <= {1'b0, shift_reg[7:1]};
                            tx        <= shift_reg[1];
                            bit_idx   <= bit_idx + 1'b1;
                        end
                    end
                end

                uart_pkg::tx_stop: begin
                    if (bit_done) begin
                        tx_active <= 1'b0;
                        state     <= uart_pkg::tx_idle;
                    end
                end

                default: begin
                    state <= uart_pkg::tx_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Line must rest at mark level between frames
    idle_line_high: assert property (
        @(posedge input_clk) disable iff (!reset)
        (state == uart_pkg::tx_idle) |-> tx
    );

endmodule
